/* tb.f */
source/robot_pkg.sv
source/ultrasonic_ranger.sv
source/moving_average.sv
source/drive_logic.sv
source/command_translator.sv
source/telemetry_reporter.sv
source/uart_arbiter.sv
source/uart_tx.sv
source/robot_top.sv
testbench/tb_robot_top.sv

/* Makefile */
# Verilator simulation of the robot ultrasonic path

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_robot_top with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -j 0 --top-module tb_robot_top -f tb.f -o tb_robot_top
	./obj_dir/tb_robot_top

clean:
	rm -rf obj_dir

/* testbench/tb_robot_top.sv */
`timescale 1ns/100ps

module tb_robot_top;

	localparam int measure_period = 2000;	// room for one shot plus six frames
	localparam int trigger_cycles = 3;
	localparam int cycles_per_unit = 2;
	localparam int echo_timeout = 600;
	localparam int stop_distance = 40;
	localparam int direction_center = 16;
	localparam int direction_margin = 3;
	localparam int clocks_per_bit = 4;
	localparam int measurements = 40;

	logic clk_50 = 1'b0;
	logic reset;
	logic echo;
	logic trigger;
	logic [4:0] direction;
	logic direction_valid;
	logic serial_out;
	logic [7:0] distance_led;

	int hist [0:1][0:3];	// model history, row 0 distance, row 1 direction
	int avg_dir;	// model averaged direction
	int exp_led;	// latest model averaged distance
	int exp_cmd [$];	// letters still owed by the DUT
	int exp_tel [$];	// report values still owed
	int msg_pos;	// 0 outside a report, 1..4 inside
	int msg_value;	// digits collected so far

	robot_top #(
		.measure_period(measure_period),
		.trigger_cycles(trigger_cycles),
		.cycles_per_unit(cycles_per_unit),
		.echo_timeout(echo_timeout),
		.stop_distance(stop_distance),
		.direction_center(direction_center),
		.direction_margin(direction_margin),
		.clocks_per_bit(clocks_per_bit)
	) i_dut (
		.clk_50(clk_50),
		.reset(reset),
		.echo(echo),
		.trigger(trigger),
		.direction(direction),
		.direction_valid(direction_valid),
		.serial_out(serial_out),
		.distance_led(distance_led)
	);

	always #20 clk_50 = ~clk_50;	// 40 ns period

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		if (got != expected) begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, expected);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	// four tap average, history starts at zero
	function int shift_in(input int which, input int sample);
		int total;
		total = 0;
		for (int i = 3; i > 0; i--) begin
			hist[which][i] = hist[which][i-1];
		end
		hist[which][0] = sample;
		for (int i = 0; i < 4; i++) begin
			total += hist[which][i];
		end
		return total / 4;
	endfunction

	function int expected_letter(input int avg_d, input int avg_direction);
		if (avg_d < stop_distance) begin
			return 32'h53;	// S, obstacle close
		end else if (avg_direction < direction_center - direction_margin) begin
			return 32'h4C;	// L
		end else if (avg_direction > direction_center + direction_margin) begin
			return 32'h52;	// R
		end
		return 32'h46;	// F, inside dead band
	endfunction

	task automatic wait_trigger_rise;
		int cycles;
		cycles = 0;
		while (trigger !== 1'b1) begin
			@(negedge clk_50);
			cycles++;
			if (cycles > measure_period + 10) abort_run("trigger never went high");
		end
	endtask

	task automatic measure_trigger_width;
		int width;
		width = 0;
		while (trigger === 1'b1) begin
			width++;	// counts this cycle
			@(negedge clk_50);
			if (width > trigger_cycles + 10) abort_run("trigger stuck high");
		end
		check_value("trigger width", width, trigger_cycles);
	endtask

	task automatic strobe_direction(input int value);
		direction = 5'(value);
		direction_valid = 1'b1;
		@(negedge clk_50);
		direction_valid = 1'b0;
		@(negedge clk_50);
		avg_dir = shift_in(1, value);
	endtask

	task automatic wait_drain;
		int cycles;
		cycles = 0;
		while (exp_cmd.size() != 0 || exp_tel.size() != 0) begin
			@(negedge clk_50);
			cycles++;
			if (cycles > echo_timeout + 20 * 11 * clocks_per_bit) begin
				abort_run("serial messages did not arrive in time");
			end
		end
	endtask

	// one trigger, a few direction strobes, one echo or none
	task automatic run_measurement(input int index);
		int kind;
		int width;
		int raw;
		int avg_d;
		int strobes;
		wait_trigger_rise();
		measure_trigger_width();
		strobes = 1 + int'($urandom % 3);
		repeat (strobes) strobe_direction(direction_center - 12 + int'($urandom % 25));
		repeat (int'($urandom % 16)) @(negedge clk_50);
		if (index < 4) begin
			kind = index % 3;	// first shots walk the average up to 255
		end else begin
			kind = int'($urandom % 16);
		end
		if (kind == 0) begin
			raw = 255;	// no echo at all
		end else begin
			if (kind == 1) begin
				width = 510 + int'($urandom % 90);	// unit count saturates
			end else if (kind == 2) begin
				width = echo_timeout + 1 + int'($urandom % 40);	// echo too long
			end else begin
				width = (stop_distance - 15 + int'($urandom % 30)) * cycles_per_unit
					+ int'($urandom % cycles_per_unit);
			end
			echo = 1'b1;
			repeat (width) @(negedge clk_50);
			echo = 1'b0;
			raw = width / cycles_per_unit;
			if (raw > 255 || width > echo_timeout) begin
				raw = 255;
			end
		end
		avg_d = shift_in(0, raw);
		exp_led = avg_d;
		exp_tel.push_back(avg_d);
		exp_cmd.push_back(expected_letter(avg_d, avg_dir));
		wait_drain();
	endtask

	// sorts decoded bytes into letters and D reports
	task automatic handle_rx_byte(input logic [7:0] rx);
		int expected;
		if (msg_pos == 0) begin
			if (rx == 8'h44) begin
				msg_pos = 1;	// report header
				msg_value = 0;
			end else if (rx == 8'h53 || rx == 8'h46 || rx == 8'h4C || rx == 8'h52) begin
				if (exp_cmd.size() == 0) abort_run("command letter with no pending decision");
				expected = exp_cmd.pop_front();
				check_value("command letter", int'(rx), expected);
			end else begin
				abort_run("unexpected byte outside a report");
			end
		end else if (msg_pos < 4) begin
			if (rx < 8'h30 || rx > 8'h39) abort_run("report interrupted by a non-digit byte");
			msg_value = msg_value * 10 + int'(rx - 8'h30);
			msg_pos++;
		end else begin
			check_value("report terminator", int'(rx), 32'h0A);
			msg_pos = 0;
			if (exp_tel.size() == 0) abort_run("distance report with no pending sample");
			expected = exp_tel.pop_front();
			check_value("telemetry distance", msg_value, expected);
			check_value("distance_led", int'(distance_led), exp_led);
		end
	endtask

	initial begin : serial_decoder
		logic [7:0] rx;
		forever begin
			@(negedge clk_50);
			if (reset === 1'b0 && serial_out === 1'b0) begin
				repeat (clocks_per_bit / 2) @(negedge clk_50);	// middle of start bit
				if (serial_out !== 1'b0) abort_run("start bit too short on serial_out");
				for (int i = 0; i < 8; i++) begin
					repeat (clocks_per_bit) @(negedge clk_50);
					rx[i] = serial_out;	// lsb first
				end
				repeat (clocks_per_bit) @(negedge clk_50);
				if (serial_out !== 1'b1) abort_run("stop bit missing on serial_out");
				handle_rx_byte(rx);
			end
		end
	end

	initial begin
		reset = 1'b1;
		echo = 1'b0;
		direction = '0;
		direction_valid = 1'b0;
		msg_pos = 0;
		msg_value = 0;
		avg_dir = 0;
		exp_led = 0;
		for (int i = 0; i < 4; i++) begin
			hist[0][i] = 0;
			hist[1][i] = 0;
		end
		void'($urandom(32'h1786));
		repeat (3) @(negedge clk_50);	// three rising edges in reset
		reset = 1'b0;
		check_value("serial_out after reset", int'(serial_out), 1);
		check_value("trigger after reset", int'(trigger), 0);
		check_value("distance_led after reset", int'(distance_led), 0);
		for (int m = 0; m < measurements; m++) begin
			run_measurement(m);
		end
		$display("All tests passed");
		$finish;
	end

endmodule

/* source/robot_top.sv */
`timescale 1ns/100ps

module robot_top #(
	parameter int measure_period = 3_000_000,	// 60 ms between shots
	parameter int trigger_cycles = 500,	// 10 us trigger
	parameter int cycles_per_unit = 2900,	// 58 us per cm
	parameter int echo_timeout = 750_000,
	parameter int stop_distance = 20,
	parameter int direction_center = 12,
	parameter int direction_margin = 3,
	parameter int clocks_per_bit = 434	// 115200 baud
) (
	input logic clk_50,
	input logic reset,
	input logic echo,
	output logic trigger,
	input logic [robot_pkg::direction_width-1:0] direction,
	input logic direction_valid,
	output logic serial_out,
	output logic [robot_pkg::distance_width-1:0] distance_led
);
	import robot_pkg::*;

	logic [distance_width-1:0] raw_distance;
	logic raw_distance_valid;
	logic [distance_width-1:0] avg_distance;
	logic avg_distance_valid;
	logic [direction_width-1:0] avg_direction;
	logic avg_direction_valid;
	logic [cmd_width-1:0] command;
	logic command_valid;

	// producer side of the shared link
	logic cmd_request;
	logic [7:0] cmd_byte;
	logic cmd_last;
	logic cmd_taken;
	logic tel_request;
	logic [7:0] tel_byte;
	logic tel_last;
	logic tel_taken;

	// transmitter side
	logic tx_start;
	logic [7:0] tx_data;
	logic tx_busy;

	assign distance_led = avg_distance;

	ultrasonic_ranger #(
		.measure_period(measure_period),
		.trigger_cycles(trigger_cycles),
		.cycles_per_unit(cycles_per_unit),
		.echo_timeout(echo_timeout)
	) i_ranger (
		.clk_50(clk_50),
		.reset(reset),
		.echo(echo),
		.trigger(trigger),
		.distance(raw_distance),
		.distance_valid(raw_distance_valid)
	);

	moving_average #(.width(distance_width)) i_distance_avg (
		.clk_50(clk_50),
		.reset(reset),
		.sample(raw_distance),
		.sample_valid(raw_distance_valid),
		.average(avg_distance),
		.average_valid(avg_distance_valid)
	);

	moving_average #(.width(direction_width)) i_direction_avg (
		.clk_50(clk_50),
		.reset(reset),
		.sample(direction),
		.sample_valid(direction_valid),
		.average(avg_direction),
		.average_valid(avg_direction_valid)
	);

	drive_logic #(
		.stop_distance(stop_distance),
		.direction_center(direction_center),
		.direction_margin(direction_margin)
	) i_drive (
		.clk_50(clk_50),
		.reset(reset),
		.avg_distance(avg_distance),
		.avg_distance_valid(avg_distance_valid),
		.avg_direction(avg_direction),
		.avg_direction_valid(avg_direction_valid),
		.command(command),
		.command_valid(command_valid)
	);

	command_translator i_translator (
		.clk_50(clk_50),
		.reset(reset),
		.command(command),
		.command_valid(command_valid),
		.request(cmd_request),
		.tx_byte(cmd_byte),
		.last(cmd_last),
		.taken(cmd_taken)
	);

	telemetry_reporter i_reporter (
		.clk_50(clk_50),
		.reset(reset),
		.avg_distance(avg_distance),
		.avg_distance_valid(avg_distance_valid),
		.request(tel_request),
		.tx_byte(tel_byte),
		.last(tel_last),
		.taken(tel_taken)
	);

	uart_arbiter i_arbiter (
		.clk_50(clk_50),
		.reset(reset),
		.cmd_request(cmd_request),
		.cmd_byte(cmd_byte),
		.cmd_last(cmd_last),
		.cmd_taken(cmd_taken),
		.tel_request(tel_request),
		.tel_byte(tel_byte),
		.tel_last(tel_last),
		.tel_taken(tel_taken),
		.tx_busy(tx_busy),
		.tx_start(tx_start),
		.tx_data(tx_data)
	);

	uart_tx #(.clocks_per_bit(clocks_per_bit)) i_uart_tx (
		.clk_50(clk_50),
		.reset(reset),
		.start(tx_start),
		.data(tx_data),
		.busy(tx_busy),
		.serial_out(serial_out)	// link to base station
	);

endmodule

/* source/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx #(
	parameter int clocks_per_bit = 434
) (
	input logic clk_50,
	input logic reset,
	input logic start,
	input logic [7:0] data,
	output logic busy,
	output logic serial_out
);

	localparam int baud_width = $clog2(clocks_per_bit + 1);

	logic [baud_width-1:0] baud_cnt;	// cycles into the current bit
	logic [3:0] bit_idx;	// 0 start, 1..8 data, 9 stop
	logic [9:0] frame;	// shifts out LSB first

	assign serial_out = busy ? frame[0] : 1'b1;	// idle line high

	always_ff @(posedge clk_50 or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			baud_cnt <= '0;
			bit_idx <= '0;
		end else if (!busy) begin
			baud_cnt <= '0;
			bit_idx <= '0;
			if (start) begin
				busy <= 1'b1;	// start bit from next cycle
			end
		end else if (baud_cnt == baud_width'(clocks_per_bit - 1)) begin
			baud_cnt <= '0;
			if (bit_idx == 4'd9) begin
				busy <= 1'b0;	// stop bit done
			end else begin
				bit_idx <= bit_idx + 1'b1;
			end
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_50) begin
		if (!busy && start) begin
			frame <= {1'b1, data, 1'b0};	// stop, data, start
		end else if (busy && baud_cnt == baud_width'(clocks_per_bit - 1)) begin
			frame <= {1'b1, frame[9:1]};
		end
	end

endmodule

/* source/uart_arbiter.sv */
`timescale 1ns/100ps

module uart_arbiter (
	input logic clk_50,
	input logic reset,
	input logic cmd_request,
	input logic [7:0] cmd_byte,
	input logic cmd_last,
	output logic cmd_taken,
	input logic tel_request,
	input logic [7:0] tel_byte,
	input logic tel_last,
	output logic tel_taken,
	input logic tx_busy,
	output logic tx_start,
	output logic [7:0] tx_data
);

	logic locked;	// inside a message
	logic owner_tel;	// producer holding the lock
	logic pick_tel;
	logic pick_last;

	// command producer first, unless telemetry owns the link
	assign pick_tel = locked ? owner_tel : (!cmd_request && tel_request);
	assign pick_last = pick_tel ? tel_last : cmd_last;

	assign cmd_taken = !tx_busy && !pick_tel && cmd_request;
	assign tel_taken = !tx_busy && pick_tel && tel_request;
	assign tx_start = cmd_taken || tel_taken;	// same cycle as taken
	assign tx_data = pick_tel ? tel_byte : cmd_byte;

	always_ff @(posedge clk_50 or posedge reset) begin
		if (reset) begin
			locked <= 1'b0;
			owner_tel <= 1'b0;
		end else if (tx_start) begin
			locked <= !pick_last;	// released on the last byte
			owner_tel <= pick_tel;
		end
	end

endmodule

/* source/telemetry_reporter.sv */
`timescale 1ns/100ps

module telemetry_reporter (
	input logic clk_50,
	input logic reset,
	input logic [robot_pkg::distance_width-1:0] avg_distance,
	input logic avg_distance_valid,
	output logic request,
	output logic [7:0] tx_byte,
	output logic last,
	input logic taken
);
	import robot_pkg::*;

	typedef enum logic [1:0] {st_idle, st_hundreds, st_tens, st_send} state_t;

	state_t state;
	logic [distance_width-1:0] remainder;	// ends up as the ones digit
	logic [1:0] hundreds;	// at most 2 for an 8 bit value
	logic [3:0] tens;
	logic [2:0] index;	// byte position in the report

	assign request = (state == st_send);
	assign last = (index == 3'd4);	// newline closes the message

	always_comb begin
		case (index)
			3'd0: tx_byte = ascii_d;
			3'd1: tx_byte = ascii_zero + 8'(hundreds);
			3'd2: tx_byte = ascii_zero + 8'(tens);
			3'd3: tx_byte = ascii_zero + 8'(remainder);
			default: tx_byte = ascii_newline;
		endcase
	end

	always_ff @(posedge clk_50 or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			index <= '0;
		end else begin
			case (state)
				st_idle: begin
					index <= '0;
					if (avg_distance_valid) begin
						state <= st_hundreds;	// samples are dropped while busy
					end
				end
				st_hundreds: begin
					if (remainder < 8'd100) begin
						state <= st_tens;
					end
				end
				st_tens: begin
					if (remainder < 8'd10) begin
						state <= st_send;	// digits ready
					end
				end
				st_send: begin
					if (taken) begin
						if (last) begin
							state <= st_idle;
						end else begin
							index <= index + 1'b1;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// digit split by repeated subtraction
	always_ff @(posedge clk_50) begin
		if (state == st_idle && avg_distance_valid) begin
			remainder <= avg_distance;
			hundreds <= '0;
			tens <= '0;
		end else if (state == st_hundreds && remainder >= 8'd100) begin
			remainder <= remainder - 8'd100;
			hundreds <= hundreds + 1'b1;
		end else if (state == st_tens && remainder >= 8'd10) begin
			remainder <= remainder - 8'd10;
			tens <= tens + 1'b1;
		end
	end

endmodule

/* source/command_translator.sv */
`timescale 1ns/100ps

module command_translator (
	input logic clk_50,
	input logic reset,
	input logic [robot_pkg::cmd_width-1:0] command,
	input logic command_valid,
	output logic request,
	output logic [7:0] tx_byte,
	output logic last,
	input logic taken
);
	import robot_pkg::*;

	logic [7:0] letter;

	always_comb begin
		case (command)
			cmd_forward: letter = ascii_forward;
			cmd_left: letter = ascii_left;
			cmd_right: letter = ascii_right;
			default: letter = ascii_stop;
		endcase
	end

	assign last = 1'b1;	// every command is one byte

	always_ff @(posedge clk_50 or posedge reset) begin
		if (reset) begin
			request <= 1'b0;
		end else if (command_valid) begin
			request <= 1'b1;	// newer command replaces a pending one
		end else if (taken) begin
			request <= 1'b0;
		end
	end

	always_ff @(posedge clk_50) begin
		if (command_valid) begin
			tx_byte <= letter;
		end
	end

endmodule

/* source/drive_logic.sv */
`timescale 1ns/100ps

module drive_logic #(
	parameter int stop_distance = 20,
	parameter int direction_center = 12,
	parameter int direction_margin = 3
) (
	input logic clk_50,
	input logic reset,
	input logic [robot_pkg::distance_width-1:0] avg_distance,
	input logic avg_distance_valid,
	input logic [robot_pkg::direction_width-1:0] avg_direction,
	input logic avg_direction_valid,
	output logic [robot_pkg::cmd_width-1:0] command,
	output logic command_valid
);
	import robot_pkg::*;

	logic [direction_width-1:0] direction_q;	// latest averaged direction
	logic [cmd_width-1:0] decision;

	always_comb begin
		if (int'(avg_distance) < stop_distance) begin
			decision = cmd_stop;	// obstacle close
		end else if (int'(direction_q) < direction_center - direction_margin) begin
			decision = cmd_left;
		end else if (int'(direction_q) > direction_center + direction_margin) begin
			decision = cmd_right;
		end else begin
			decision = cmd_forward;	// inside dead band
		end
	end

	always_ff @(posedge clk_50 or posedge reset) begin
		if (reset) begin
			direction_q <= '0;
			command <= cmd_stop;
			command_valid <= 1'b0;
		end else begin
			if (avg_direction_valid) begin
				direction_q <= avg_direction;
			end
			command_valid <= avg_distance_valid;	// one decision per distance update
			if (avg_distance_valid) begin
				command <= decision;
			end
		end
	end

endmodule

/* source/moving_average.sv */
`timescale 1ns/100ps

module moving_average #(
	parameter int width = 8
) (
	input logic clk_50,
	input logic reset,
	input logic [width-1:0] sample,
	input logic sample_valid,
	output logic [width-1:0] average,
	output logic average_valid
);

	logic [width-1:0] history [0:3];	// newest at index 0
	logic [width+1:0] sum;	// running sum of the four entries
	logic [width+1:0] next_sum;

	assign next_sum = sum + (width+2)'(sample) - (width+2)'(history[3]);

	always_ff @(posedge clk_50 or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 4; i++) begin
				history[i] <= '0;	// average starts from zero
			end
			sum <= '0;
			average <= '0;
			average_valid <= 1'b0;
		end else begin
			average_valid <= sample_valid;
			if (sample_valid) begin
				history[0] <= sample;
				for (int i = 1; i < 4; i++) begin
					history[i] <= history[i-1];	// oldest drops out
				end
				sum <= next_sum;
				average <= next_sum[width+1:2];	// divide by four
			end
		end
	end

endmodule

/* source/ultrasonic_ranger.sv */
`timescale 1ns/100ps

module ultrasonic_ranger #(
	parameter int measure_period = 3_000_000,
	parameter int trigger_cycles = 500,
	parameter int cycles_per_unit = 2900,
	parameter int echo_timeout = 750_000
) (
	input logic clk_50,
	input logic reset,
	input logic echo,
	output logic trigger,
	output logic [robot_pkg::distance_width-1:0] distance,
	output logic distance_valid
);
	import robot_pkg::*;

	localparam int period_width = $clog2(measure_period);
	localparam int longest_phase = (trigger_cycles > echo_timeout) ? trigger_cycles : echo_timeout;
	localparam int timer_width = $clog2(longest_phase + 2);
	localparam int pre_width = $clog2(cycles_per_unit + 1);

	typedef enum logic [1:0] {st_idle, st_trigger, st_wait_echo, st_timing} state_t;

	state_t state;
	logic [period_width-1:0] period_cnt;	// free running measure period
	logic period_wrap;
	logic [timer_width-1:0] phase_cnt;	// trigger length, then echo wait
	logic [timer_width-1:0] echo_cnt;	// echo high cycles, for timeout
	logic [pre_width-1:0] pre_cnt;	// cycles within one distance unit
	logic [distance_width-1:0] units;	// saturating unit count
	logic count_en;

	assign period_wrap = (period_cnt == period_width'(measure_period - 1));
	assign trigger = (state == st_trigger);	// high for trigger_cycles
	assign count_en = echo && (state == st_wait_echo || state == st_timing);

	always_ff @(posedge clk_50 or posedge reset) begin
		if (reset) begin
			period_cnt <= '0;
		end else if (period_wrap) begin
			period_cnt <= '0;
		end else begin
			period_cnt <= period_cnt + 1'b1;
		end
	end

	// echo width prescaler, one unit per cycles_per_unit cycles
	always_ff @(posedge clk_50 or posedge reset) begin
		if (reset) begin
			pre_cnt <= '0;
			units <= '0;
		end else if (state == st_trigger) begin
			pre_cnt <= '0;	// fresh count for each shot
			units <= '0;
		end else if (count_en) begin
			if (pre_cnt == pre_width'(cycles_per_unit - 1)) begin
				pre_cnt <= '0;
				if (units != '1) begin
					units <= units + 1'b1;	// stops at 255
				end
			end else begin
				pre_cnt <= pre_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_50 or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			phase_cnt <= '0;
			echo_cnt <= '0;
			distance <= '0;
			distance_valid <= 1'b0;
		end else begin
			distance_valid <= 1'b0;	// one cycle pulse
			case (state)
				st_idle: begin
					phase_cnt <= '0;
					if (period_wrap) begin
						state <= st_trigger;
					end
				end
				st_trigger: begin
					if (phase_cnt == timer_width'(trigger_cycles - 1)) begin
						phase_cnt <= '0;
						state <= st_wait_echo;
					end else begin
						phase_cnt <= phase_cnt + 1'b1;
					end
				end
				st_wait_echo: begin
					if (echo) begin
						echo_cnt <= timer_width'(1);	// this cycle already counts
						state <= st_timing;
					end else if (phase_cnt == timer_width'(echo_timeout - 1)) begin
						distance <= '1;	// no echo, report max range
						distance_valid <= 1'b1;
						state <= st_idle;
					end else begin
						phase_cnt <= phase_cnt + 1'b1;
					end
				end
				st_timing: begin
					if (!echo) begin
						distance <= units;	// echo fell
						distance_valid <= 1'b1;
						state <= st_idle;
					end else if (echo_cnt == timer_width'(echo_timeout)) begin
						distance <= '1;	// echo too long
						distance_valid <= 1'b1;
						state <= st_idle;
					end else begin
						echo_cnt <= echo_cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

/* source/robot_pkg.sv */
package robot_pkg;

	// data widths
	localparam int distance_width = 8;	// ranger sample, cm units
	localparam int direction_width = 5;	// steering input, 0 is far left
	localparam int cmd_width = 2;	// motion command code

	// motion command codes
	localparam logic [cmd_width-1:0] cmd_stop = 2'd0;
	localparam logic [cmd_width-1:0] cmd_forward = 2'd1;
	localparam logic [cmd_width-1:0] cmd_left = 2'd2;
	localparam logic [cmd_width-1:0] cmd_right = 2'd3;

	// letters sent to the base station
	localparam logic [7:0] ascii_stop = 8'h53;	// S
	localparam logic [7:0] ascii_forward = 8'h46;	// F
	localparam logic [7:0] ascii_left = 8'h4C;	// L
	localparam logic [7:0] ascii_right = 8'h52;	// R

	// telemetry framing
	localparam logic [7:0] ascii_d = 8'h44;	// D, distance report header
	localparam logic [7:0] ascii_newline = 8'h0A;	// ends a report
	localparam logic [7:0] ascii_zero = 8'h30;	// digit base

endpackage
